/* compile.f */
hdl/rp_cache_pkg.sv
hdl/rp_decoupler.sv
hdl/rp_shutdown_ctrl.sv
hdl/wt_dcache_lite.sv
hdl/rp_cache_top.sv
verif/rp_cache_checker.sv
verif/rp_cache_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := rp_cache_tb
FILELIST  := compile.f
OBJ_DIR   := obj_dir
FLAGS     := --timing --assert
SIM_FLAGS := --binary -j 0 --Mdir $(OBJ_DIR)
PASS_MSG  := sim passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* verif/rp_cache_tb.sv */
// Cache partition testbench

`timescale 1ns/1ps

module rp_cache_tb;

  import rp_cache_pkg::*;

  localparam int unsigned NumSets       = 16;
  localparam int unsigned QuiesceCycles = 20;
  // tests take under 300 cycles even with the longest memory delays
  localparam int unsigned MaxCycles     = 4000;

  logic        clk_i;
  logic        reset_i;
  logic        rp_reset_i;
  logic        decouple_i;
  logic        flush_i;
  logic        shutdown_req_i;
  core_req_t   core_req;
  logic        mem_ack_i;
  logic        mem_rtrn_vld_i;
  mem_rtrn_t   mem_rtrn;
  core_rsp_t   core_rsp_o;
  logic        mem_req_valid_o;
  mem_req_t    mem_req_o;
  logic        flush_ack_o;
  logic        miss_o;
  logic        wbuffer_empty_o;
  logic        shutdown_ack_o;
  logic [31:0] pr_cycles_o;

  integer      seed = 9;
  int          errors = 0;
  int          checks = 0;
  int          cycle_cnt = 0;
  int          mem_req_count = 0;
  int          store_rtrn_count = 0;
  logic        miss_seen;

  logic [DATA_W-1:0] mem [65536];
  logic [DATA_W-1:0] shadow [logic [ADDR_W-1:0]];
  logic [DATA_W-1:0] exp_q [$];

  rp_cache_top #(
    .NumSets       ( NumSets       ),
    .QuiesceCycles ( QuiesceCycles )
  ) i_dut (
    .clk_i           ( clk_i           ),
    .reset_i         ( reset_i         ),
    .rp_reset_i      ( rp_reset_i      ),
    .decouple_i      ( decouple_i      ),
    .flush_i         ( flush_i         ),
    .shutdown_req_i  ( shutdown_req_i  ),
    .core_req_i      ( core_req        ),
    .mem_ack_i       ( mem_ack_i       ),
    .mem_rtrn_vld_i  ( mem_rtrn_vld_i  ),
    .mem_rtrn_i      ( mem_rtrn        ),
    .core_rsp_o      ( core_rsp_o      ),
    .mem_req_valid_o ( mem_req_valid_o ),
    .mem_req_o       ( mem_req_o       ),
    .flush_ack_o     ( flush_ack_o     ),
    .miss_o          ( miss_o          ),
    .wbuffer_empty_o ( wbuffer_empty_o ),
    .shutdown_ack_o  ( shutdown_ack_o  ),
    .pr_cycles_o     ( pr_cycles_o     )
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= MaxCycles) begin
      $display("timeout after %0d cycles, the DUT stopped responding", cycle_cnt);
      $display("sim failed");
      $finish;
    end
  end

  ////////////////////////////////////////
  // reference and checks
  ////////////////////////////////////////

  // memory image as seen by the core, stores on top of the fill pattern
  function automatic logic [DATA_W-1:0] ref_load(input logic [ADDR_W-1:0] addr);
    if (shadow.exists(addr)) begin
      return shadow[addr];
    end
    return {16'h0000, addr} ^ 32'h5A5A0000;
  endfunction

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("FAILED at %0t ns: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  // static side view of an idle or isolated partition
  task automatic check_idle_outputs();
    check_bit("core_rsp_o.gnt", core_rsp_o.gnt, 1'b0);
    check_bit("core_rsp_o.rvalid", core_rsp_o.rvalid, 1'b0);
    check_bit("mem_req_valid_o", mem_req_valid_o, 1'b0);
    check_bit("flush_ack_o", flush_ack_o, 1'b0);
    check_bit("miss_o", miss_o, 1'b0);
    check_bit("wbuffer_empty_o", wbuffer_empty_o, 1'b1);
  endtask

  // every load response against the expected queue
  always @(negedge clk_i) begin
    if (!reset_i && core_rsp_o.rvalid) begin
      checks++;
      assert (exp_q.size() > 0) else begin
        errors++;
        $display("ERROR at %0t ns: read response without an outstanding load", $time);
      end
      if (exp_q.size() > 0) begin
        check_eq("core_rsp_o.rdata", core_rsp_o.rdata, exp_q.pop_front());
      end
    end
  end

  always @(negedge clk_i) begin
    if (miss_o) begin
      miss_seen = 1'b1;
    end
  end

  ////////////////////////////////////////
  // memory model
  ////////////////////////////////////////

  initial begin : mem_model
    int       d;
    mem_req_t req;
    mem_ack_i      = 1'b0;
    mem_rtrn_vld_i = 1'b0;
    mem_rtrn       = '0;
    for (int a = 0; a < 65536; a++) begin
      mem[a] = a ^ 32'h5A5A0000;
    end
    forever begin
      @(negedge clk_i);
      if (mem_req_valid_o) begin
        req = mem_req_o;
        d = {$random(seed)} % 4;
        repeat (d) @(posedge clk_i);
        @(posedge clk_i);
        #1 mem_ack_i = 1'b1;
        mem_req_count++;
        if (req.rtype == MEM_STORE) begin
          mem[req.addr] = req.data;
        end
        @(posedge clk_i);
        #1 mem_ack_i = 1'b0;
        d = 1 + ({$random(seed)} % 4);
        repeat (d - 1) begin
          @(posedge clk_i);
          #1;
        end
        mem_rtrn_vld_i = 1'b1;
        mem_rtrn.rtype = req.rtype;
        mem_rtrn.data  = mem[req.addr];
        if (req.rtype == MEM_STORE) begin
          store_rtrn_count++;
        end
        @(posedge clk_i);
        #1 mem_rtrn_vld_i = 1'b0;
      end
    end
  end

  ////////////////////////////////////////
  // stimulus tasks
  ////////////////////////////////////////

  task automatic load_word(input logic [ADDR_W-1:0] addr, input logic exp_miss);
    int reqs_before;
    @(posedge clk_i);
    #1;
    exp_q.push_back(ref_load(addr));
    miss_seen   = 1'b0;
    reqs_before = mem_req_count;
    core_req    = '{req: 1'b1, we: 1'b0, addr: addr, wdata: '0};
    @(negedge clk_i);
    while (!core_rsp_o.gnt) @(negedge clk_i);
    check_bit("core_rsp_o.rvalid at gnt", core_rsp_o.rvalid, 1'b0);
    @(posedge clk_i);
    #1 core_req.req = 1'b0;
    @(negedge clk_i);
    check_bit("core_rsp_o.rvalid after gnt", core_rsp_o.rvalid, 1'b1);
    check_bit("miss_o", miss_seen, exp_miss);
    if (!exp_miss) begin
      check_eq("memory requests on hit", mem_req_count, reqs_before);
    end
  endtask

  task automatic store_word(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
    int rtrn_before;
    @(posedge clk_i);
    #1;
    rtrn_before  = store_rtrn_count;
    shadow[addr] = data;
    core_req     = '{req: 1'b1, we: 1'b1, addr: addr, wdata: data};
    @(negedge clk_i);
    while (!core_rsp_o.gnt) @(negedge clk_i);
    check_bit("wbuffer_empty_o at gnt", wbuffer_empty_o, 1'b0);
    @(posedge clk_i);
    #1 core_req.req = 1'b0;
    @(negedge clk_i);
    while (!wbuffer_empty_o) @(negedge clk_i);
    check_eq("store returns", store_rtrn_count, rtrn_before + 1);
  endtask

  task automatic flush_cache();
    int cyc;
    int extra_acks;
    @(posedge clk_i);
    #1 flush_i = 1'b1;
    cyc = 0;
    extra_acks = 0;
    @(negedge clk_i);
    while (!flush_ack_o) begin
      @(negedge clk_i);
      cyc++;
    end
    check_eq("flush_ack_o latency", cyc, NumSets + 1);
    @(posedge clk_i);
    #1 flush_i = 1'b0;
    // long enough to see a second full flush
    repeat (NumSets + 4) begin
      @(negedge clk_i);
      if (flush_ack_o) extra_acks++;
    end
    check_eq("extra flush_ack_o pulses", extra_acks, 0);
  endtask

  task automatic shutdown_sequence();
    int cyc;
    @(posedge clk_i);
    #1 shutdown_req_i = 1'b1;
    cyc = 0;
    @(negedge clk_i);
    while (!shutdown_ack_o) begin
      check_eq("pr_cycles_o", pr_cycles_o, cyc);
      @(negedge clk_i);
      cyc++;
    end
    check_eq("shutdown_ack_o latency", cyc, QuiesceCycles + 1);
    repeat (4) begin
      @(negedge clk_i);
      cyc++;
      check_bit("shutdown_ack_o held", shutdown_ack_o, 1'b1);
      check_eq("pr_cycles_o", pr_cycles_o, cyc);
    end
    @(posedge clk_i);
    #1 shutdown_req_i = 1'b0;
    repeat (2) @(negedge clk_i);
    check_bit("shutdown_ack_o after release", shutdown_ack_o, 1'b0);
    check_eq("pr_cycles_o after release", pr_cycles_o, 0);
  endtask

  // cut off in the middle of a store, which then never reaches memory
  task automatic decouple_sequence(input logic [ADDR_W-1:0] addr);
    @(posedge clk_i);
    #1 core_req = '{req: 1'b1, we: 1'b1, addr: addr, wdata: ~ref_load(addr)};
    @(posedge clk_i);
    #1 decouple_i = 1'b1;
    core_req = '{req: 1'b1, we: 1'b0, addr: addr, wdata: '0};
    flush_i  = 1'b1;
    repeat (4) begin
      @(negedge clk_i);
      check_idle_outputs();
    end
    @(posedge clk_i);
    #1 rp_reset_i = 1'b1;
    repeat (2) @(posedge clk_i);
    #1 rp_reset_i = 1'b0;
    // held load and flush must not reach the fresh partition
    repeat (NumSets + 4) begin
      @(negedge clk_i);
      check_idle_outputs();
    end
    @(posedge clk_i);
    #1 core_req.req = 1'b0;
    flush_i = 1'b0;
    @(posedge clk_i);
    #1 decouple_i = 1'b0;
    load_word(addr, 1'b1);
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    reset_i        = 1'b1;
    rp_reset_i     = 1'b0;
    decouple_i     = 1'b0;
    flush_i        = 1'b0;
    shutdown_req_i = 1'b0;
    core_req       = '0;
    repeat (3) @(posedge clk_i);
    #1 reset_i = 1'b0;
    check_idle_outputs();
    check_bit("shutdown_ack_o after reset", shutdown_ack_o, 1'b0);
    check_eq("pr_cycles_o after reset", pr_cycles_o, 0);

    // miss, then hit
    load_word(16'h0013, 1'b1);
    load_word(16'h0013, 1'b0);
    // same index, other tag evicts
    load_word(16'h0123, 1'b1);
    load_word(16'h0013, 1'b1);
    load_word(16'h0045, 1'b1);

    // write-through on hit, no allocate on miss
    store_word(16'h0013, $random(seed));
    load_word(16'h0013, 1'b0);
    store_word(16'h0200, $random(seed));
    load_word(16'h0200, 1'b1);
    load_word(16'h0200, 1'b0);

    flush_cache();
    load_word(16'h0013, 1'b1);
    load_word(16'h0045, 1'b1);

    shutdown_sequence();
    decouple_sequence(16'h0013);

    repeat (5) @(negedge clk_i);
    checks++;
    assert (exp_q.size() == 0) else begin
      errors++;
      $display("ERROR: %0d loads never returned data", exp_q.size());
    end

    $display("errors: %0d of %0d checks", errors, checks);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* verif/rp_cache_checker.sv */
// Cache partition protocol checker

`timescale 1ns/1ps

module rp_cache_checker (
  input logic                    clk_i,
  input logic                    reset_i,
  input logic                    decouple_i,
  input logic                    shutdown_req_i,
  input logic                    shutdown_ack_o,
  input rp_cache_pkg::core_req_t core_req_i,
  input rp_cache_pkg::core_rsp_t core_rsp_o,
  input logic                    mem_req_valid_o,
  input rp_cache_pkg::mem_req_t  mem_req_o,
  input logic                    mem_ack_i
);

  gnt_needs_req: assert property (@(posedge clk_i) disable iff (reset_i)
    core_rsp_o.gnt |-> core_req_i.req)
    else $error("grant without a pending request");

  // request held until memory takes it
  mem_req_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    (mem_req_valid_o && !mem_ack_i) |=> $stable(mem_req_o))
    else $error("memory request changed before its acknowledge");

  no_mem_req_decoupled: assert property (@(posedge clk_i) disable iff (reset_i)
    decouple_i |-> !mem_req_valid_o)
    else $error("memory request while decoupled");

  // ack may lag the dropped request by one cycle
  ack_needs_req: assert property (@(posedge clk_i) disable iff (reset_i)
    shutdown_ack_o |-> (shutdown_req_i || $past(shutdown_req_i)))
    else $error("shutdown acknowledge without a request");

endmodule

bind rp_cache_top rp_cache_checker i_checker (
  .clk_i           ( clk_i           ),
  .reset_i         ( reset_i         ),
  .decouple_i      ( decouple_i      ),
  .shutdown_req_i  ( shutdown_req_i  ),
  .shutdown_ack_o  ( shutdown_ack_o  ),
  .core_req_i      ( core_req_i      ),
  .core_rsp_o      ( core_rsp_o      ),
  .mem_req_valid_o ( mem_req_valid_o ),
  .mem_req_o       ( mem_req_o       ),
  .mem_ack_i       ( mem_ack_i       )
);

/* hdl/rp_cache_top.sv */
// Data cache partition top level

`timescale 1ns/1ps

module rp_cache_top #(
  parameter int unsigned NumSets       = 16,
  parameter int unsigned QuiesceCycles = 20
) (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    rp_reset_i,
  input  logic                    decouple_i,
  input  logic                    flush_i,
  input  logic                    shutdown_req_i,
  input  rp_cache_pkg::core_req_t core_req_i,
  input  logic                    mem_ack_i,
  input  logic                    mem_rtrn_vld_i,
  input  rp_cache_pkg::mem_rtrn_t mem_rtrn_i,
  output rp_cache_pkg::core_rsp_t core_rsp_o,
  output logic                    mem_req_valid_o,
  output rp_cache_pkg::mem_req_t  mem_req_o,
  output logic                    flush_ack_o,
  output logic                    miss_o,
  output logic                    wbuffer_empty_o,
  output logic                    shutdown_ack_o,
  output logic [31:0]             pr_cycles_o
);

  import rp_cache_pkg::*;

  // partition side of the boundary
  logic      rp_reset;
  core_req_t rp_core_req;
  core_rsp_t rp_core_rsp;
  logic      rp_flush;
  logic      rp_flush_ack;
  logic      rp_miss;
  logic      rp_wbuffer_empty;
  logic      rp_mem_req_valid;
  mem_req_t  rp_mem_req;
  logic      rp_mem_ack;
  logic      rp_mem_rtrn_vld;
  mem_rtrn_t rp_mem_rtrn;

  rp_decoupler i_decoupler (
    .reset_i            ( reset_i          ),
    .rp_reset_i         ( rp_reset_i       ),
    .decouple_i         ( decouple_i       ),
    .s_core_req_i       ( core_req_i       ),
    .s_flush_i          ( flush_i          ),
    .s_mem_ack_i        ( mem_ack_i        ),
    .s_mem_rtrn_vld_i   ( mem_rtrn_vld_i   ),
    .s_mem_rtrn_i       ( mem_rtrn_i       ),
    .rp_core_rsp_i      ( rp_core_rsp      ),
    .rp_mem_req_valid_i ( rp_mem_req_valid ),
    .rp_mem_req_i       ( rp_mem_req       ),
    .rp_flush_ack_i     ( rp_flush_ack     ),
    .rp_miss_i          ( rp_miss          ),
    .rp_wbuffer_empty_i ( rp_wbuffer_empty ),
    .s_core_rsp_o       ( core_rsp_o       ),
    .s_mem_req_valid_o  ( mem_req_valid_o  ),
    .s_mem_req_o        ( mem_req_o        ),
    .s_flush_ack_o      ( flush_ack_o      ),
    .s_miss_o           ( miss_o           ),
    .s_wbuffer_empty_o  ( wbuffer_empty_o  ),
    .rp_reset_o         ( rp_reset         ),
    .rp_core_req_o      ( rp_core_req      ),
    .rp_flush_o         ( rp_flush         ),
    .rp_mem_ack_o       ( rp_mem_ack       ),
    .rp_mem_rtrn_vld_o  ( rp_mem_rtrn_vld  ),
    .rp_mem_rtrn_o      ( rp_mem_rtrn      )
  );

  // static logic, runs on the system reset
  rp_shutdown_ctrl #(
    .QuiesceCycles ( QuiesceCycles )
  ) i_shutdown_ctrl (
    .clk_i          ( clk_i          ),
    .reset_i        ( reset_i        ),
    .shutdown_req_i ( shutdown_req_i ),
    .shutdown_ack_o ( shutdown_ack_o ),
    .pr_cycles_o    ( pr_cycles_o    )
  );

  // reconfigurable module
  wt_dcache_lite #(
    .NumSets ( NumSets )
  ) i_dcache (
    .clk_i           ( clk_i            ),
    .reset_i         ( rp_reset         ),
    .core_req_i      ( rp_core_req      ),
    .core_rsp_o      ( rp_core_rsp      ),
    .flush_i         ( rp_flush         ),
    .flush_ack_o     ( rp_flush_ack     ),
    .miss_o          ( rp_miss          ),
    .wbuffer_empty_o ( rp_wbuffer_empty ),
    .mem_req_valid_o ( rp_mem_req_valid ),
    .mem_req_o       ( rp_mem_req       ),
    .mem_ack_i       ( rp_mem_ack       ),
    .mem_rtrn_vld_i  ( rp_mem_rtrn_vld  ),
    .mem_rtrn_i      ( rp_mem_rtrn      )
  );

endmodule

/* hdl/wt_dcache_lite.sv */
// Write-through data cache

`timescale 1ns/1ps

module wt_dcache_lite #(
  parameter int unsigned NumSets = 16
) (
  input  logic                    clk_i,
  input  logic                    reset_i,
  // core port
  input  rp_cache_pkg::core_req_t core_req_i,
  output rp_cache_pkg::core_rsp_t core_rsp_o,
  // cache management
  input  logic                    flush_i,
  output logic                    flush_ack_o,
  output logic                    miss_o,
  output logic                    wbuffer_empty_o,
  // memory port
  output logic                    mem_req_valid_o,
  output rp_cache_pkg::mem_req_t  mem_req_o,
  input  logic                    mem_ack_i,
  input  logic                    mem_rtrn_vld_i,
  input  rp_cache_pkg::mem_rtrn_t mem_rtrn_i
);

  import rp_cache_pkg::*;

  localparam int unsigned IdxW = $clog2(NumSets);
  localparam int unsigned TagW = ADDR_W - IdxW;

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    MISS_REQ,
    MISS_WAIT,
    STORE_REQ,
    STORE_WAIT,
    FLUSH
  } state_e;

  state_e state_q, state_d;

  // captured request
  logic              we_q;
  logic [ADDR_W-1:0] addr_q;
  logic [DATA_W-1:0] wdata_q;

  // line storage
  logic [NumSets-1:0] valid_q;
  logic [TagW-1:0]    tag_q  [NumSets];
  logic [DATA_W-1:0]  data_q [NumSets];

  logic [IdxW-1:0]   flush_cnt_q;
  logic              flush_ack_q;
  logic              rvalid_q;
  logic [DATA_W-1:0] rdata_q;

  logic [IdxW-1:0] idx;
  logic [TagW-1:0] tag;
  logic            lookup;
  logic            hit;
  logic            rtrn_load;
  logic            rtrn_store;
  logic            flush_last;

  assign idx        = addr_q[IdxW-1:0];
  assign tag        = addr_q[ADDR_W-1:IdxW];
  assign lookup     = (state_q == LOOKUP);
  assign hit        = valid_q[idx] && (tag_q[idx] == tag);
  assign rtrn_load  = mem_rtrn_vld_i && (mem_rtrn_i.rtype == MEM_LOAD);
  assign rtrn_store = mem_rtrn_vld_i && (mem_rtrn_i.rtype == MEM_STORE);
  assign flush_last = (flush_cnt_q == IdxW'(NumSets - 1));

  ////////////////////////////////////////
  // control FSM
  ////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        // ack still up means this flush was just served
        if (flush_i && !flush_ack_q) begin
          state_d = FLUSH;
        end else if (core_req_i.req) begin
          state_d = LOOKUP;
        end
      end
      LOOKUP: begin
        if (we_q) begin
          state_d = STORE_REQ;
        end else if (!hit) begin
          state_d = MISS_REQ;
        end else begin
          state_d = IDLE;
        end
      end
      MISS_REQ:   if (mem_ack_i) state_d = MISS_WAIT;
      MISS_WAIT:  if (rtrn_load) state_d = IDLE;
      STORE_REQ:  if (mem_ack_i) state_d = STORE_WAIT;
      STORE_WAIT: if (rtrn_store) state_d = IDLE;
      FLUSH:      if (flush_last) state_d = IDLE;
      default:    state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q     <= IDLE;
      valid_q     <= '0;
      flush_cnt_q <= '0;
      flush_ack_q <= 1'b0;
      rvalid_q    <= 1'b0;
    end else begin
      state_q     <= state_d;
      flush_cnt_q <= (state_q == FLUSH) ? flush_cnt_q + 1'b1 : '0;
      flush_ack_q <= (state_q == FLUSH) && flush_last;
      rvalid_q    <= (lookup && !we_q && hit) || ((state_q == MISS_WAIT) && rtrn_load);
      // one line per cycle during flush
      if (state_q == FLUSH) begin
        valid_q[flush_cnt_q] <= 1'b0;
      end else if ((state_q == MISS_WAIT) && rtrn_load) begin
        valid_q[idx] <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // datapath
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (state_q == IDLE) begin
      we_q    <= core_req_i.we;
      addr_q  <= core_req_i.addr;
      wdata_q <= core_req_i.wdata;
    end
    rdata_q <= lookup ? data_q[idx] : mem_rtrn_i.data;
    // store updates only a hit line, no allocate
    if (lookup && we_q && hit) begin
      data_q[idx] <= wdata_q;
    end else if ((state_q == MISS_WAIT) && rtrn_load) begin
      tag_q[idx]  <= tag;
      data_q[idx] <= mem_rtrn_i.data;
    end
  end

  // outputs
  assign core_rsp_o.gnt    = (lookup && (we_q || hit)) || ((state_q == MISS_WAIT) && rtrn_load);
  assign core_rsp_o.rvalid = rvalid_q;
  assign core_rsp_o.rdata  = rdata_q;

  assign miss_o      = lookup && !we_q && !hit;
  assign flush_ack_o = flush_ack_q;

  // a granted store counts as buffered until memory returns
  assign wbuffer_empty_o = !((lookup && we_q) || (state_q == STORE_REQ) ||
                             (state_q == STORE_WAIT));

  assign mem_req_valid_o = (state_q == MISS_REQ) || (state_q == STORE_REQ);
  assign mem_req_o.rtype = we_q ? MEM_STORE : MEM_LOAD;
  assign mem_req_o.addr  = addr_q;
  assign mem_req_o.data  = wdata_q;

endmodule

/* hdl/rp_shutdown_ctrl.sv */
// Partition shutdown controller

`timescale 1ns/1ps

module rp_shutdown_ctrl #(
  parameter int unsigned QuiesceCycles = 20
) (
  input  logic        clk_i,
  input  logic        reset_i,
  input  logic        shutdown_req_i,
  output logic        shutdown_ack_o,
  output logic [31:0] pr_cycles_o
);

  localparam int unsigned CntW = $clog2(QuiesceCycles + 1);

  logic [CntW-1:0] quiesce_cnt_q;
  logic            quiesce_done;
  logic            ack_q;
  logic [31:0]     pr_cycles_q;

  assign quiesce_done = (quiesce_cnt_q == CntW'(QuiesceCycles));

  ////////////////////////////////////////
  // quiesce wait
  ////////////////////////////////////////

  // counter saturates at the limit, ack stays up while the request holds
  always_ff @(posedge clk_i) begin
    if (reset_i || !shutdown_req_i) begin
      quiesce_cnt_q <= '0;
      ack_q         <= 1'b0;
    end else begin
      if (!quiesce_done) begin
        quiesce_cnt_q <= quiesce_cnt_q + 1'b1;
      end
      if (quiesce_done) begin
        ack_q <= 1'b1;
      end
    end
  end

  // time spent in reconfiguration
  always_ff @(posedge clk_i) begin
    if (reset_i || !shutdown_req_i) begin
      pr_cycles_q <= '0;
    end else begin
      pr_cycles_q <= pr_cycles_q + 32'd1;
    end
  end

  assign shutdown_ack_o = ack_q;
  assign pr_cycles_o    = pr_cycles_q;

endmodule

/* hdl/rp_decoupler.sv */
// Partition boundary decoupler

`timescale 1ns/1ps

module rp_decoupler (
  // system and partition control
  input  logic                    reset_i,
  input  logic                    rp_reset_i,
  input  logic                    decouple_i,
  // static side, toward the partition
  input  rp_cache_pkg::core_req_t s_core_req_i,
  input  logic                    s_flush_i,
  input  logic                    s_mem_ack_i,
  input  logic                    s_mem_rtrn_vld_i,
  input  rp_cache_pkg::mem_rtrn_t s_mem_rtrn_i,
  // partition side, toward the static logic
  input  rp_cache_pkg::core_rsp_t rp_core_rsp_i,
  input  logic                    rp_mem_req_valid_i,
  input  rp_cache_pkg::mem_req_t  rp_mem_req_i,
  input  logic                    rp_flush_ack_i,
  input  logic                    rp_miss_i,
  input  logic                    rp_wbuffer_empty_i,
  // static side outputs
  output rp_cache_pkg::core_rsp_t s_core_rsp_o,
  output logic                    s_mem_req_valid_o,
  output rp_cache_pkg::mem_req_t  s_mem_req_o,
  output logic                    s_flush_ack_o,
  output logic                    s_miss_o,
  output logic                    s_wbuffer_empty_o,
  // partition side outputs
  output logic                    rp_reset_o,
  output rp_cache_pkg::core_req_t rp_core_req_o,
  output logic                    rp_flush_o,
  output logic                    rp_mem_ack_o,
  output logic                    rp_mem_rtrn_vld_o,
  output rp_cache_pkg::mem_rtrn_t rp_mem_rtrn_o
);

  // partition held in reset by either source
  assign rp_reset_o = reset_i | rp_reset_i;

  ////////////////////////////////////////
  // static to partition
  ////////////////////////////////////////

  always_comb begin
    rp_core_req_o     = s_core_req_i;
    // address and write data pass, only the request level is blanked
    rp_core_req_o.req = s_core_req_i.req & ~decouple_i;
  end

  assign rp_flush_o        = s_flush_i & ~decouple_i;
  assign rp_mem_ack_o      = s_mem_ack_i & ~decouple_i;
  assign rp_mem_rtrn_vld_o = s_mem_rtrn_vld_i & ~decouple_i;
  assign rp_mem_rtrn_o     = s_mem_rtrn_i;

  ////////////////////////////////////////
  // partition to static
  ////////////////////////////////////////

  always_comb begin
    s_core_rsp_o        = rp_core_rsp_i;
    s_core_rsp_o.gnt    = rp_core_rsp_i.gnt & ~decouple_i;
    s_core_rsp_o.rvalid = rp_core_rsp_i.rvalid & ~decouple_i;
  end

  assign s_mem_req_valid_o = rp_mem_req_valid_i & ~decouple_i;
  assign s_mem_req_o       = rp_mem_req_i;
  assign s_flush_ack_o     = rp_flush_ack_i & ~decouple_i;
  assign s_miss_o          = rp_miss_i & ~decouple_i;

  // an isolated partition looks idle to the static side
  assign s_wbuffer_empty_o = rp_wbuffer_empty_i | decouple_i;

endmodule

/* hdl/rp_cache_pkg.sv */
// Cache partition shared types

package rp_cache_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////

  // word address and data word
  localparam int unsigned ADDR_W = 16;
  localparam int unsigned DATA_W = 32;

  ////////////////////////////////////////
  // memory transaction kind
  ////////////////////////////////////////

  typedef enum logic {
    MEM_LOAD  = 1'b0,
    MEM_STORE = 1'b1
  } mem_rtype_e;

  ////////////////////////////////////////
  // core side
  ////////////////////////////////////////

  // req is a level, held with the rest until gnt
  typedef struct packed {
    logic              req;
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } core_req_t;

  // gnt and rvalid are single cycle pulses
  typedef struct packed {
    logic              gnt;
    logic              rvalid;
    logic [DATA_W-1:0] rdata;
  } core_rsp_t;

  ////////////////////////////////////////
  // memory side
  ////////////////////////////////////////

  // data only meaningful for stores
  typedef struct packed {
    mem_rtype_e        rtype;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
  } mem_req_t;

  typedef struct packed {
    mem_rtype_e        rtype;
    logic [DATA_W-1:0] data;
  } mem_rtrn_t;

endpackage
